//--- source/vdp_timing_pkg.sv
package vdp_timing_pkg;

	// Scanline number, as wide as the chip's V counter.
	typedef logic [8:0] v_count_t;

	// First line of vertical blanking.
	localparam v_count_t VBLANK_START = 9'd192;

	// Top of the count range. The next line is 0.
	localparam v_count_t LAST_LINE = 9'd511;

	// PAL runs 0..242, then 442..511.
	// That gives 313 lines per frame.
	localparam v_count_t PAL_JUMP_FROM = 9'd242;
	localparam v_count_t PAL_JUMP_TO = 9'd442;

	// NTSC runs 0..218, then 469..511.
	// That gives 262 lines per frame.
	localparam v_count_t NTSC_JUMP_FROM = 9'd218;
	localparam v_count_t NTSC_JUMP_TO = 9'd469;

	// Vertical sync window, PAL.
	localparam v_count_t PAL_VSYNC_ON = 9'd240;
	localparam v_count_t PAL_VSYNC_OFF = 9'd458;

	// Vertical sync window, NTSC.
	localparam v_count_t NTSC_VSYNC_ON = 9'd216;
	localparam v_count_t NTSC_VSYNC_OFF = 9'd485;

endpackage

//--- source/vdp_reg_pkg.sv
package vdp_reg_pkg;

	// Host side register address and data.
	typedef logic [3:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;

	// Register map.
	localparam reg_addr_t REG_MODE = 4'd0; // Video standard and irq enable.
	localparam reg_addr_t REG_LINE_IRQ = 4'd10; // Line interrupt reload value.

	// Mode register layout. Bit 0 is pal, bit 1 is line_irq_en.
	typedef struct packed {
		logic [5:0] unused;
		logic line_irq_en; // Enables the line interrupt pulse.
		logic pal; // 1 selects 313 line PAL timing.
	} mode_reg_t;

endpackage

//--- source/vdp_regs.sv
`timescale 1ns/1ps

module vdp_regs import vdp_reg_pkg::*; (
	input logic MCLK,
	input logic reset_i,
	input logic reg_we_i,
	input reg_addr_t reg_addr_i,
	input reg_data_t reg_data_i,
	output mode_reg_t mode_o,
	output reg_data_t irq_reload_o
);

	logic mode_sel;
	logic irq_sel;
	mode_reg_t mode_q;
	reg_data_t irq_reload_q;

	// Address decode. Other addresses hit nothing.
	assign mode_sel = reg_we_i && (reg_addr_i == REG_MODE);
	assign irq_sel = reg_we_i && (reg_addr_i == REG_LINE_IRQ);

	// Mode register.
	always_ff @(posedge MCLK) begin
		if (reset_i) begin
			mode_q <= '0;
		end else if (mode_sel) begin
			mode_q <= mode_reg_t'(reg_data_i);
		end
	end

	// Line interrupt reload value.
	// Picked up by the counter at its next reload.
	always_ff @(posedge MCLK) begin
		if (reset_i) begin
			irq_reload_q <= '0;
		end else if (irq_sel) begin
			irq_reload_q <= reg_data_i;
		end
	end

	assign mode_o = mode_q;
	assign irq_reload_o = irq_reload_q;

endmodule

//--- source/v_counter.sv
`timescale 1ns/1ps

module v_counter import vdp_timing_pkg::*, vdp_reg_pkg::*; (
	input logic MCLK,
	input logic reset_i,
	input logic line_end_i,
	input mode_reg_t mode_i,
	output v_count_t vcount_o
);

	v_count_t vcount_q;
	v_count_t vcount_next;
	v_count_t jump_from;
	v_count_t jump_to;
	logic at_jump;
	logic at_last;

	// Jump points depend on the video standard.
	assign jump_from = mode_i.pal ? PAL_JUMP_FROM : NTSC_JUMP_FROM;
	assign jump_to = mode_i.pal ? PAL_JUMP_TO : NTSC_JUMP_TO;

	assign at_jump = (vcount_q == jump_from);
	assign at_last = (vcount_q == LAST_LINE);

	// Next line number.
	always_comb begin
		if (at_jump) begin
			vcount_next = jump_to; // Skip the unused part of the range.
		end else if (at_last) begin
			vcount_next = '0; // End of frame.
		end else begin
			vcount_next = vcount_q + 9'd1;
		end
	end

	// Advances once per line end.
	always_ff @(posedge MCLK) begin
		if (reset_i) begin
			vcount_q <= '0;
		end else if (line_end_i) begin
			vcount_q <= vcount_next;
		end
	end

	assign vcount_o = vcount_q;

endmodule

//--- source/v_decode.sv
`timescale 1ns/1ps

module v_decode import vdp_timing_pkg::*, vdp_reg_pkg::*; #(
	parameter v_count_t VBLANK_LINE = VBLANK_START
) (
	input logic MCLK,
	input logic reset_i,
	input v_count_t vcount_i,
	input mode_reg_t mode_i,
	output logic vblank_o,
	output logic vsync_o
);

	v_count_t vsync_on_line;
	v_count_t vsync_off_line;
	logic blank_d;
	logic sync_set;
	logic sync_clr;
	logic vblank_q;
	logic vsync_q;

	// Sync window for the selected standard.
	assign vsync_on_line = mode_i.pal ? PAL_VSYNC_ON : NTSC_VSYNC_ON;
	assign vsync_off_line = mode_i.pal ? PAL_VSYNC_OFF : NTSC_VSYNC_OFF;

	// Line decode.
	// Everything below the active height is blanked, including the jumped range.
	assign blank_d = (vcount_i >= VBLANK_LINE);
	assign sync_set = (vcount_i == vsync_on_line);
	assign sync_clr = (vcount_i == vsync_off_line);

	always_ff @(posedge MCLK) begin
		if (reset_i) begin
			vblank_q <= 1'b0;
		end else begin
			vblank_q <= blank_d;
		end
	end

	// Set/reset flag, holds between the two lines.
	always_ff @(posedge MCLK) begin
		if (reset_i) begin
			vsync_q <= 1'b0;
		end else if (sync_set) begin
			vsync_q <= 1'b1;
		end else if (sync_clr) begin
			vsync_q <= 1'b0;
		end
	end

	assign vblank_o = vblank_q;
	assign vsync_o = vsync_q;

endmodule

//--- source/line_irq_counter.sv
`timescale 1ns/1ps

module line_irq_counter import vdp_reg_pkg::*; (
	input logic MCLK,
	input logic reset_i,
	input logic line_end_i,
	input logic vblank_i,
	input mode_reg_t mode_i,
	input reg_data_t irq_reload_i,
	output logic line_irq_o
);

	reg_data_t count_q;
	logic count_zero;
	logic reload;
	logic fire;
	logic line_irq_q;

	assign count_zero = (count_q == '0);

	// Held at the reload value through blanking.
	// Also reloads when it runs out during the active area.
	assign reload = line_end_i && (vblank_i || count_zero);

	// Underflow in the active area raises the interrupt if enabled.
	assign fire = line_end_i && !vblank_i && count_zero && mode_i.line_irq_en;

	always_ff @(posedge MCLK) begin
		if (reset_i) begin
			count_q <= '0;
		end else if (reload) begin
			count_q <= irq_reload_i;
		end else if (line_end_i) begin
			count_q <= count_q - 8'd1; // One step per active line.
		end
	end

	// Single cycle pulse, registered.
	always_ff @(posedge MCLK) begin
		if (reset_i) begin
			line_irq_q <= 1'b0;
		end else begin
			line_irq_q <= fire;
		end
	end

	assign line_irq_o = line_irq_q;

endmodule

//--- source/vdp_vtiming.sv
`timescale 1ns/1ps

module vdp_vtiming import vdp_timing_pkg::*, vdp_reg_pkg::*; #(
	parameter v_count_t VBLANK_LINE = VBLANK_START
) (
	input logic MCLK,
	input logic reset_i,
	input logic line_end_i,
	input logic reg_we_i,
	input reg_addr_t reg_addr_i,
	input reg_data_t reg_data_i,
	output v_count_t vcount_o,
	output logic vblank_o,
	output logic vsync_o,
	output logic line_irq_o
);

	mode_reg_t mode;
	reg_data_t irq_reload;

	// Host registers.
	vdp_regs u_regs (
		.MCLK(MCLK),
		.reset_i(reset_i),
		.reg_we_i(reg_we_i),
		.reg_addr_i(reg_addr_i),
		.reg_data_i(reg_data_i),
		.mode_o(mode),
		.irq_reload_o(irq_reload)
	);

	// Scanline counter.
	v_counter u_v_counter (
		.MCLK(MCLK),
		.reset_i(reset_i),
		.line_end_i(line_end_i),
		.mode_i(mode),
		.vcount_o(vcount_o)
	);

	// Blank and sync flags, one cycle behind the count.
	v_decode #(
		.VBLANK_LINE(VBLANK_LINE)
	) u_v_decode (
		.MCLK(MCLK),
		.reset_i(reset_i),
		.vcount_i(vcount_o),
		.mode_i(mode),
		.vblank_o(vblank_o),
		.vsync_o(vsync_o)
	);

	// Line interrupt, sees the blank flag of the line just ended.
	line_irq_counter u_line_irq (
		.MCLK(MCLK),
		.reset_i(reset_i),
		.line_end_i(line_end_i),
		.vblank_i(vblank_o),
		.mode_i(mode),
		.irq_reload_i(irq_reload),
		.line_irq_o(line_irq_o)
	);

endmodule

//--- verif/vdp_vtiming_checker.sv
`timescale 1ns/1ps

module vdp_vtiming_checker import vdp_timing_pkg::*; (
	input logic MCLK,
	input logic reset_i,
	input logic line_end_i,
	input v_count_t vcount_i,
	input logic vblank_i,
	input logic line_irq_i
);

	int unsigned fail_count = 0; // Polled by the testbench.

	// The interrupt is a single cycle pulse.
	irq_single_cycle: assert property (@(posedge MCLK) disable iff (reset_i)
		$past(line_irq_i) |-> !line_irq_i)
	else begin
		$error("line_irq_o stayed high for two cycles");
		fail_count = fail_count + 1;
	end

	// The count only moves right after a line end.
	vcount_on_line_end: assert property (@(posedge MCLK) disable iff (reset_i)
		(vcount_i != $past(vcount_i)) |-> $past(line_end_i))
	else begin
		$error("vcount_o changed without a line end");
		fail_count = fail_count + 1;
	end

	vblank_after_reset: assert property (@(posedge MCLK)
		$fell(reset_i) |-> !vblank_i)
	else begin
		$error("vblank_o set right after reset");
		fail_count = fail_count + 1;
	end

endmodule

bind vdp_vtiming vdp_vtiming_checker u_checker (
	.MCLK(MCLK),
	.reset_i(reset_i),
	.line_end_i(line_end_i),
	.vcount_i(vcount_o),
	.vblank_i(vblank_o),
	.line_irq_i(line_irq_o)
);

//--- verif/vdp_vtiming_tb.sv
`timescale 1ns/1ps

module vdp_vtiming_tb import vdp_timing_pkg::*, vdp_reg_pkg::*;;

	localparam int NUM_LINES = 2000;
	localparam int MIN_GAP = 4;
	localparam int MAX_GAP = 12;
	localparam int TIMEOUT_CYCLES = NUM_LINES * MAX_GAP + 6000; // Worst case plus margin.

	logic MCLK;
	logic reset_i;
	logic line_end_i;
	logic reg_we_i;
	reg_addr_t reg_addr_i;
	reg_data_t reg_data_i;
	v_count_t vcount_o;
	logic vblank_o;
	logic vsync_o;
	logic line_irq_o;

	// Reference model state.
	mode_reg_t m_mode;
	reg_data_t m_reload;
	v_count_t m_vcount;
	logic m_vblank;
	logic m_vsync;
	reg_data_t m_irq_cnt;
	logic m_irq;

	logic checking;
	logic cur_pal; // Standard the stimulus keeps in the mode register.
	logic irq_en;
	int irq_pulses;
	int cycle_count;

	vdp_vtiming #(
		.VBLANK_LINE(VBLANK_START)
	) dut (
		.MCLK(MCLK),
		.reset_i(reset_i),
		.line_end_i(line_end_i),
		.reg_we_i(reg_we_i),
		.reg_addr_i(reg_addr_i),
		.reg_data_i(reg_data_i),
		.vcount_o(vcount_o),
		.vblank_o(vblank_o),
		.vsync_o(vsync_o),
		.line_irq_o(line_irq_o)
	);

	initial begin
		MCLK = 1'b0;
		forever #2 MCLK = ~MCLK;
	end

	task automatic stop_failed();
		$display("TEST FAILED");
		$fatal(1, "testbench stopped after a failure");
	endtask

	task automatic check_count(input v_count_t got, input v_count_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: vcount_o is %0d, expected %0d", $time, got, exp);
			stop_failed();
		end
	endtask

	task automatic check_flags(input logic got_blank, input logic got_sync,
			input logic exp_blank, input logic exp_sync);
		if ((got_blank !== exp_blank) || (got_sync !== exp_sync)) begin
			$display("mismatch at %0t: vblank/vsync are %b/%b, expected %b/%b at line %0d",
				$time, got_blank, got_sync, exp_blank, exp_sync, m_vcount);
			stop_failed();
		end
	endtask

	task automatic check_irq(input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: line_irq_o is %b, expected %b", $time, got, exp);
			stop_failed();
		end
	endtask

	// Line after the given one, from the frame layout of each standard.
	function automatic v_count_t next_line(input v_count_t line, input logic pal);
		if (pal && (line == PAL_JUMP_FROM)) begin
			return PAL_JUMP_TO;
		end
		if (!pal && (line == NTSC_JUMP_FROM)) begin
			return NTSC_JUMP_TO;
		end
		if (line == LAST_LINE) begin
			return '0;
		end
		return line + 9'd1;
	endfunction

	function automatic v_count_t sync_on_line(input logic pal);
		return pal ? PAL_VSYNC_ON : NTSC_VSYNC_ON;
	endfunction

	function automatic v_count_t sync_off_line(input logic pal);
		return pal ? PAL_VSYNC_OFF : NTSC_VSYNC_OFF;
	endfunction

	// Mode byte with random filler in the unused bits.
	function automatic reg_data_t mode_byte();
		mode_reg_t m;
		m.unused = 6'($urandom_range(0, 63));
		m.line_irq_en = irq_en;
		m.pal = cur_pal;
		return reg_data_t'(m);
	endfunction

	// Model, updated from the inputs the DUT samples at the same edge.
	always @(posedge MCLK) begin : model
		v_count_t line_now;
		logic blank_now;
		logic zero_now;
		line_now = m_vcount;
		blank_now = m_vblank;
		zero_now = (m_irq_cnt == 8'd0);
		if (reset_i) begin
			m_mode = '0;
			m_reload = '0;
			m_vcount = '0;
			m_vblank = 1'b0;
			m_vsync = 1'b0;
			m_irq_cnt = '0;
			m_irq = 1'b0;
		end else begin
			m_vblank = (line_now >= VBLANK_START);
			if (line_now == sync_on_line(m_mode.pal)) begin
				m_vsync = 1'b1;
			end else if (line_now == sync_off_line(m_mode.pal)) begin
				m_vsync = 1'b0;
			end
			m_irq = line_end_i && !blank_now && zero_now && m_mode.line_irq_en;
			if (m_irq) begin
				irq_pulses = irq_pulses + 1;
			end
			if (line_end_i) begin
				m_vcount = next_line(line_now, m_mode.pal);
				if (blank_now || zero_now) begin
					m_irq_cnt = m_reload;
				end else begin
					m_irq_cnt = m_irq_cnt - 8'd1;
				end
			end
			// Register writes last, the blocks above see the old values.
			if (reg_we_i && (reg_addr_i == REG_MODE)) begin
				m_mode = mode_reg_t'(reg_data_i);
			end else if (reg_we_i && (reg_addr_i == REG_LINE_IRQ)) begin
				m_reload = reg_data_i;
			end
		end
	end

	// Outputs are stable at the falling edge.
	always @(negedge MCLK) begin
		if (checking) begin
			check_count(vcount_o, m_vcount);
			check_flags(vblank_o, vsync_o, m_vblank, m_vsync);
			check_irq(line_irq_o, m_irq);
			if (dut.u_checker.fail_count != 0) begin
				$display("a bound assertion on the DUT outputs failed at %0t", $time);
				stop_failed();
			end
		end
	end

	always @(posedge MCLK) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_failed();
		end
	end

	task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
		@(posedge MCLK);
		reg_we_i <= 1'b1;
		reg_addr_i <= addr;
		reg_data_i <= data;
		@(posedge MCLK);
		reg_we_i <= 1'b0;
	endtask

	// One random write in the current cycle.
	task automatic random_write();
		int kind;
		reg_addr_t addr;
		kind = $urandom_range(0, 2);
		reg_we_i <= 1'b1;
		if (kind == 0) begin
			irq_en = 1'($urandom_range(0, 1));
			reg_addr_i <= REG_MODE;
			reg_data_i <= mode_byte();
		end else if (kind == 1) begin
			reg_addr_i <= REG_LINE_IRQ;
			reg_data_i <= reg_data_t'($urandom_range(0, 24));
		end else begin
			addr = reg_addr_t'($urandom_range(1, 14));
			if (addr >= 4'd10) begin
				addr = addr + 4'd1; // Skips REG_LINE_IRQ.
			end
			reg_addr_i <= addr;
			reg_data_i <= reg_data_t'($urandom_range(0, 255));
		end
	endtask

	// Line end pulse, then idle cycles with occasional writes.
	task automatic run_line(input int gap, input logic switch_mode);
		int i;
		@(posedge MCLK);
		reg_we_i <= 1'b0;
		line_end_i <= 1'b1;
		for (i = 1; i < gap; i++) begin
			@(posedge MCLK);
			line_end_i <= 1'b0;
			if (switch_mode && (i == 2)) begin
				reg_we_i <= 1'b1;
				reg_addr_i <= REG_MODE;
				reg_data_i <= mode_byte();
			end else if ($urandom_range(0, 11) == 0) begin
				random_write();
			end else begin
				reg_we_i <= 1'b0;
			end
		end
	endtask

	initial begin
		int line_idx;
		int gap;
		logic switch_mode;
		void'($urandom(32'hcdc6));
		reset_i = 1'b1;
		line_end_i = 1'b0;
		reg_we_i = 1'b0;
		reg_addr_i = '0;
		reg_data_i = '0;
		checking = 1'b0;
		cur_pal = 1'b0;
		irq_en = 1'b0;
		irq_pulses = 0;
		cycle_count = 0;
		repeat (4) @(posedge MCLK);
		reset_i <= 1'b0;

		@(negedge MCLK);
		check_count(vcount_o, '0);
		check_flags(vblank_o, vsync_o, 1'b0, 1'b0);
		check_irq(line_irq_o, 1'b0);
		checking = 1'b1;

		write_reg(REG_LINE_IRQ, 8'd5);
		irq_en = 1'b1;
		write_reg(REG_MODE, mode_byte());

		// NTSC first, PAL from line 700, NTSC again from line 1400.
		for (line_idx = 0; line_idx < NUM_LINES; line_idx++) begin
			switch_mode = 1'b0;
			if ((line_idx == 700) || (line_idx == 1400)) begin
				cur_pal = ~cur_pal;
				switch_mode = 1'b1;
			end
			gap = $urandom_range(MIN_GAP, MAX_GAP);
			run_line(gap, switch_mode);
		end
		@(posedge MCLK);
		reg_we_i <= 1'b0;
		repeat (16) @(posedge MCLK);
		@(negedge MCLK);

		if (dut.u_checker.fail_count != 0) begin
			$display("a bound assertion on the DUT outputs failed");
			stop_failed();
		end else if (irq_pulses == 0) begin
			$display("no line interrupt was raised during the run");
			stop_failed();
		end else begin
			$display("TEST OK");
			$finish;
		end
	end

endmodule

//--- all.f
source/vdp_timing_pkg.sv
source/vdp_reg_pkg.sv
source/vdp_regs.sv
source/v_counter.sv
source/v_decode.sv
source/line_irq_counter.sv
source/vdp_vtiming.sv
verif/vdp_vtiming_checker.sv
verif/vdp_vtiming_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the vertical timing testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module vdp_vtiming_tb \
	-f all.f \
	-o vdp_vtiming_sim

# Pass or fail comes from the log.
./obj_dir/vdp_vtiming_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
